// ==== all.f ====
logic/lsq_cfg_pkg.sv
logic/mem_access_pkg.sv
logic/store_queue.sv
logic/forward_align.sv
logic/load_dependence_check.sv
logic/load_buffer.sv
logic/load_store_queue.sv
tb/lsq_assertions.sv
tb/lsq_tb.sv

// ==== Bender.yml ====
package:
  name: load_store_queue

sources:
  - logic/lsq_cfg_pkg.sv
  - logic/mem_access_pkg.sv
  - logic/store_queue.sv
  - logic/forward_align.sv
  - logic/load_dependence_check.sv
  - logic/load_buffer.sv
  - logic/load_store_queue.sv
  - target: test
    files:
      - tb/lsq_assertions.sv
      - tb/lsq_tb.sv

// ==== tb/lsq_tb.sv ====
`timescale 1ns/1ps

module lsq_tb
    import lsq_cfg_pkg::*, mem_access_pkg::*;
;

    localparam int WAIT_LIMIT = 20;

    logic      clock;
    logic      rst;
    logic      flush;
    logic      sq_alloc;
    logic      sq_resolve_valid;
    sq_idx_t   sq_resolve_idx;
    word_t     sq_resolve_base;
    word_t     sq_resolve_offset;
    word_t     sq_resolve_data;
    mem_size_e sq_resolve_size;
    logic      store_commit;
    logic      lb_alloc;
    logic      lb_resolve_valid;
    lb_idx_t   lb_resolve_idx;
    word_t     lb_resolve_base;
    word_t     lb_resolve_offset;
    mem_size_e lb_resolve_size;
    logic      lb_resolve_signed;
    tag_t      lb_resolve_tag;

    sq_idx_t   sq_tail;
    logic      sq_full;
    lb_idx_t   lb_alloc_idx;
    logic      lb_full;
    logic      sq_head_resolved;
    logic      cache_write_valid;
    word_t     cache_write_addr;
    word_t     cache_write_data;
    mem_size_e cache_write_size;
    logic      cache_read_valid;
    word_t     cache_read_addr;
    mem_size_e cache_read_size;
    logic      cache_read_signed;
    tag_t      cache_read_tag;
    logic      fwd_valid;
    word_t     fwd_data;
    tag_t      fwd_tag;

    load_store_queue load_store_queue_inst (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////////////////////////
    // Checking and waiting
    ////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_equal(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            stop_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, actual, expected));
        end
    endtask

    // Stop at the first assertion failure
    always @(posedge clock) begin
        if (load_store_queue_inst.lsq_assertions_inst.fail_count != 0) begin
            stop_run("A bound assertion on the DUT failed");
        end
    end

    task automatic wait_read_valid();
        int cycles;
        cycles = 0;
        while (!cache_read_valid) begin
            if (cycles == WAIT_LIMIT) stop_run("Timed out waiting for a cache read");
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic wait_fwd_valid();
        int cycles;
        cycles = 0;
        while (!fwd_valid) begin
            if (cycles == WAIT_LIMIT) stop_run("Timed out waiting for forwarded data");
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic wait_head_resolved();
        int cycles;
        cycles = 0;
        while (!sq_head_resolved) begin
            if (cycles == WAIT_LIMIT) stop_run("Timed out waiting for a resolved store head");
            @(negedge clock);
            cycles++;
        end
    endtask

    // Expected load value from a store word, per byte offset and size
    function automatic word_t expect_load(input word_t store_word, input int byte_off,
                                          input mem_size_e size, input logic sgn);
        int    nbits;
        word_t mask;
        word_t value;
        nbits = (size == SIZE_BYTE) ? 8 : (size == SIZE_HALF) ? 16 : 32;
        value = store_word >> (8 * byte_off);
        if (nbits < 32) begin
            mask  = (32'd1 << nbits) - 32'd1;
            value = value & mask;
            if (sgn && value[nbits-1]) value = value | ~mask;
        end
        return value;
    endfunction

    ////////////////////////////////////////
    // Driving
    ////////////////////////////////////////

    task automatic alloc_store(output sq_idx_t idx);
        idx      = sq_tail;
        sq_alloc = 1'b1;
        @(negedge clock);
        sq_alloc = 1'b0;
    endtask

    task automatic resolve_store(input sq_idx_t idx, input word_t base, input word_t offset,
                                 input word_t data, input mem_size_e size);
        sq_resolve_valid  = 1'b1;
        sq_resolve_idx    = idx;
        sq_resolve_base   = base;
        sq_resolve_offset = offset;
        sq_resolve_data   = data;
        sq_resolve_size   = size;
        @(negedge clock);
        sq_resolve_valid = 1'b0;
    endtask

    task automatic alloc_load(output lb_idx_t idx);
        idx      = lb_alloc_idx;
        lb_alloc = 1'b1;
        @(negedge clock);
        lb_alloc = 1'b0;
    endtask

    task automatic resolve_load(input lb_idx_t idx, input word_t base, input word_t offset,
                                input mem_size_e size, input logic sgn, input tag_t tag);
        lb_resolve_valid  = 1'b1;
        lb_resolve_idx    = idx;
        lb_resolve_base   = base;
        lb_resolve_offset = offset;
        lb_resolve_size   = size;
        lb_resolve_signed = sgn;
        lb_resolve_tag    = tag;
        @(negedge clock);
        lb_resolve_valid = 1'b0;
    endtask

    // Commit the head and compare the cache write in the same cycle
    task automatic commit_store(input word_t addr, input word_t data, input mem_size_e size);
        wait_head_resolved();
        store_commit = 1'b1;
        #1;
        check_equal(cache_write_valid, 1, "cache_write_valid");
        check_equal(cache_write_addr, addr, "cache_write_addr");
        check_equal(cache_write_data, data, "cache_write_data");
        check_equal(cache_write_size, size, "cache_write_size");
        @(negedge clock);
        store_commit = 1'b0;
    endtask

    task automatic check_idle();
        check_equal(cache_write_valid, 0, "cache_write_valid when idle");
        check_equal(cache_read_valid, 0, "cache_read_valid when idle");
        check_equal(fwd_valid, 0, "fwd_valid when idle");
        check_equal(sq_full, 0, "sq_full when idle");
        check_equal(lb_full, 0, "lb_full when idle");
        check_equal(sq_head_resolved, 0, "sq_head_resolved when idle");
        check_equal(sq_tail, 0, "sq_tail when idle");
        check_equal(lb_alloc_idx, 0, "lb_alloc_idx when idle");
    endtask

    // Fixed window in which a blocked load must stay quiet
    task automatic expect_silent(input int cycles);
        repeat (cycles) begin
            check_equal(cache_read_valid, 0, "cache_read_valid of a blocked load");
            check_equal(fwd_valid, 0, "fwd_valid of a blocked load");
            @(negedge clock);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_load_no_store();
        lb_idx_t idx;
        word_t   base;
        word_t   offset;
        base   = $urandom();
        offset = $urandom_range(0, 255);
        alloc_load(idx);
        check_equal(idx, 0, "first load index");
        resolve_load(idx, base, offset, SIZE_HALF, 1'b1, tag_t'(5));
        // One cycle after the resolve edge
        check_equal(cache_read_valid, 1, "cache_read_valid after resolve");
        check_equal(cache_read_addr, base + offset, "cache_read_addr");
        check_equal(cache_read_size, SIZE_HALF, "cache_read_size");
        check_equal(cache_read_signed, 1, "cache_read_signed");
        check_equal(cache_read_tag, 5, "cache_read_tag");
        check_equal(fwd_valid, 0, "fwd_valid of an issued load");
        @(negedge clock);
        check_equal(cache_read_valid, 0, "cache_read_valid after issue");
        check_equal(lb_alloc_idx, 0, "lb_alloc_idx after issue");
    endtask

    task automatic forward_case(input word_t addr, input int off, input mem_size_e size,
                                input logic sgn, input tag_t tag, input word_t store_word);
        lb_idx_t idx;
        alloc_load(idx);
        resolve_load(idx, addr, word_t'(off), size, sgn, tag);
        wait_fwd_valid();
        check_equal(fwd_data, expect_load(store_word, off, size, sgn), "fwd_data");
        check_equal(fwd_tag, tag, "fwd_tag");
        check_equal(cache_read_valid, 0, "cache_read_valid of a forwarded load");
        @(negedge clock);
        check_equal(fwd_valid, 0, "fwd_valid after forward");
    endtask

    task automatic test_forward();
        sq_idx_t sidx;
        word_t   addr;
        word_t   data;
        addr = $urandom() & 32'hFFFF_FFFC;
        // Top bits set so that sign extension shows
        data = $urandom() | 32'h8000_8080;
        alloc_store(sidx);
        resolve_store(sidx, addr - 32'h40, 32'h40, data, SIZE_WORD);
        forward_case(addr, 3, SIZE_BYTE, 1'b0, tag_t'(10), data);
        forward_case(addr, 3, SIZE_BYTE, 1'b1, tag_t'(11), data);
        forward_case(addr, 2, SIZE_HALF, 1'b0, tag_t'(12), data);
        commit_store(addr, data, SIZE_WORD);
    endtask

    task automatic test_blocking();
        sq_idx_t sidx;
        lb_idx_t lidx;
        lb_idx_t fidx;
        word_t   laddr;
        word_t   data;
        laddr = $urandom() & 32'hFFFF_FFFC;
        data  = $urandom();
        // Older store still unresolved
        alloc_store(sidx);
        alloc_load(lidx);
        alloc_load(fidx);
        resolve_load(lidx, laddr, 0, SIZE_WORD, 1'b0, tag_t'(20));
        // Second load matches the store and forwards once it resolves
        resolve_load(fidx, laddr ^ 32'h1000, 0, SIZE_WORD, 1'b0, tag_t'(22));
        expect_silent(4);
        resolve_store(sidx, laddr ^ 32'h1000, 0, data, SIZE_WORD);
        wait_read_valid();
        check_equal(cache_read_addr, laddr, "cache_read_addr after store resolve");
        check_equal(cache_read_tag, 20, "cache_read_tag after store resolve");
        // Issue and forward leave in the same cycle
        check_equal(fwd_valid, 1, "fwd_valid beside a cache read");
        check_equal(fwd_data, data, "fwd_data of a full word");
        check_equal(fwd_tag, 22, "fwd_tag beside a cache read");
        commit_store(laddr ^ 32'h1000, data, SIZE_WORD);
        // Halfword store covers only half of a word load
        alloc_store(sidx);
        alloc_load(lidx);
        resolve_store(sidx, laddr, 0, data, SIZE_HALF);
        resolve_load(lidx, laddr, 0, SIZE_WORD, 1'b1, tag_t'(21));
        expect_silent(4);
        commit_store(laddr, data, SIZE_HALF);
        wait_read_valid();
        check_equal(cache_read_addr, laddr, "cache_read_addr after commit");
        check_equal(cache_read_tag, 21, "cache_read_tag after commit");
        @(negedge clock);
    endtask

    task automatic test_store_commits();
        sq_idx_t   st_idx [7];
        word_t     st_addr [7];
        word_t     st_data [7];
        mem_size_e st_size [7];
        for (int i = 0; i < 7; i++) begin
            st_addr[i] = $urandom();
            st_data[i] = $urandom();
            st_size[i] = mem_size_e'(i % 3);
            alloc_store(st_idx[i]);
            check_equal(sq_full, (i == 6), "sq_full while filling");
        end
        // Resolve out of order, youngest first
        for (int i = 6; i >= 0; i--) begin
            resolve_store(st_idx[i], st_addr[i] - 32'd8, 32'd8, st_data[i], st_size[i]);
        end
        commit_store(st_addr[0], st_data[0], st_size[0]);
        check_equal(sq_full, 0, "sq_full after one commit");
        for (int i = 1; i < 7; i++) begin
            commit_store(st_addr[i], st_data[i], st_size[i]);
        end
        check_equal(sq_head_resolved, 0, "sq_head_resolved when empty");
    endtask

    task automatic test_flush();
        sq_idx_t sidx;
        lb_idx_t lidx [8];
        for (int i = 0; i < 7; i++) begin
            alloc_store(sidx);
        end
        for (int i = 0; i < 8; i++) begin
            alloc_load(lidx[i]);
        end
        check_equal(sq_full, 1, "sq_full before flush");
        check_equal(lb_full, 1, "lb_full before flush");
        resolve_load(lidx[0], $urandom(), 0, SIZE_WORD, 1'b0, tag_t'(30));
        resolve_load(lidx[5], $urandom(), 0, SIZE_BYTE, 1'b1, tag_t'(31));
        expect_silent(3);
        flush = 1'b1;
        @(negedge clock);
        flush = 1'b0;
        check_idle();
    endtask

    initial begin
        void'($urandom(74889));
        rst               = 1'b1;
        flush             = 1'b0;
        sq_alloc          = 1'b0;
        sq_resolve_valid  = 1'b0;
        sq_resolve_idx    = '0;
        sq_resolve_base   = '0;
        sq_resolve_offset = '0;
        sq_resolve_data   = '0;
        sq_resolve_size   = SIZE_WORD;
        store_commit      = 1'b0;
        lb_alloc          = 1'b0;
        lb_resolve_valid  = 1'b0;
        lb_resolve_idx    = '0;
        lb_resolve_base   = '0;
        lb_resolve_offset = '0;
        lb_resolve_size   = SIZE_WORD;
        lb_resolve_signed = 1'b0;
        lb_resolve_tag    = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        check_idle();
        test_load_no_store();
        test_forward();
        test_blocking();
        test_store_commits();
        test_flush();

        if (load_store_queue_inst.lsq_assertions_inst.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run("A bound assertion on the DUT failed");
        end
    end

endmodule

// ==== tb/lsq_assertions.sv ====
`timescale 1ns/1ps

module lsq_assertions
    import lsq_cfg_pkg::*;
(
    input logic clock,
    input logic rst,
    input logic sq_alloc,
    input logic sq_full,
    input logic lb_alloc,
    input logic lb_full,
    input logic store_commit,
    input logic sq_head_resolved,
    input logic cache_read_valid,
    input tag_t cache_read_tag,
    input logic fwd_valid,
    input tag_t fwd_tag
);

    int fail_count;

    initial fail_count = 0;

    ////////////////////////////////////////
    // Dispatch and ROB protocol
    ////////////////////////////////////////

    a_sq_alloc: assert property (@(posedge clock) disable iff (rst) sq_alloc |-> !sq_full)
        else begin
            $error("store allocated while sq_full is high");
            fail_count++;
        end

    a_lb_alloc: assert property (@(posedge clock) disable iff (rst) lb_alloc |-> !lb_full)
        else begin
            $error("load allocated while lb_full is high");
            fail_count++;
        end

    a_commit: assert property (@(posedge clock) disable iff (rst)
        store_commit |-> sq_head_resolved)
        else begin
            $error("store commit without a resolved head");
            fail_count++;
        end

    // One load never goes to both the cache and the result bus
    a_tags: assert property (@(posedge clock) disable iff (rst)
        (cache_read_valid && fwd_valid) |-> (cache_read_tag != fwd_tag))
        else begin
            $error("cache read and forward carry the same tag");
            fail_count++;
        end

endmodule

bind load_store_queue lsq_assertions lsq_assertions_inst (
    .clock            (clock),
    .rst              (rst),
    .sq_alloc         (sq_alloc),
    .sq_full          (sq_full),
    .lb_alloc         (lb_alloc),
    .lb_full          (lb_full),
    .store_commit     (store_commit),
    .sq_head_resolved (sq_head_resolved),
    .cache_read_valid (cache_read_valid),
    .cache_read_tag   (cache_read_tag),
    .fwd_valid        (fwd_valid),
    .fwd_tag          (fwd_tag)
);

// ==== logic/load_store_queue.sv ====
`timescale 1ns/1ps

module load_store_queue
    import lsq_cfg_pkg::*, mem_access_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  logic      flush,

    input  logic      sq_alloc,
    input  logic      sq_resolve_valid,
    input  sq_idx_t   sq_resolve_idx,
    input  word_t     sq_resolve_base,
    input  word_t     sq_resolve_offset,
    input  word_t     sq_resolve_data,
    input  mem_size_e sq_resolve_size,
    input  logic      store_commit,

    input  logic      lb_alloc,
    input  logic      lb_resolve_valid,
    input  lb_idx_t   lb_resolve_idx,
    input  word_t     lb_resolve_base,
    input  word_t     lb_resolve_offset,
    input  mem_size_e lb_resolve_size,
    input  logic      lb_resolve_signed,
    input  tag_t      lb_resolve_tag,

    output sq_idx_t   sq_tail,
    output logic      sq_full,
    output lb_idx_t   lb_alloc_idx,
    output logic      lb_full,
    output logic      sq_head_resolved,

    output logic      cache_write_valid,
    output word_t     cache_write_addr,
    output word_t     cache_write_data,
    output mem_size_e cache_write_size,

    output logic      cache_read_valid,
    output word_t     cache_read_addr,
    output mem_size_e cache_read_size,
    output logic      cache_read_signed,
    output tag_t      cache_read_tag,

    output logic      fwd_valid,
    output word_t     fwd_data,
    output tag_t      fwd_tag
);

    sq_idx_t             sq_head;
    logic [SQ_DEPTH-1:0] sq_entry_resolved;
    word_t               sq_entry_addr [SQ_DEPTH];
    word_t               sq_entry_data [SQ_DEPTH];
    mem_size_e           sq_entry_size [SQ_DEPTH];

    logic [LB_DEPTH-1:0] lb_entry_resolved;
    sq_idx_t             lb_entry_age [LB_DEPTH];
    word_t               lb_entry_addr [LB_DEPTH];
    mem_size_e           lb_entry_size [LB_DEPTH];
    logic [LB_DEPTH-1:0] lb_entry_signed;

    logic [LB_DEPTH-1:0] issue_ready;
    logic [LB_DEPTH-1:0] forward_ready;
    word_t               forward_data [LB_DEPTH];

    // Effective addresses
    word_t sq_resolve_addr;
    word_t lb_resolve_addr;

    assign sq_resolve_addr = sq_resolve_base + sq_resolve_offset;
    assign lb_resolve_addr = lb_resolve_base + lb_resolve_offset;

    // Commit writes the head in the same cycle
    assign cache_write_valid = store_commit;

    store_queue store_queue_inst (
        .clock          (clock),
        .rst            (rst),
        .flush          (flush),
        .alloc          (sq_alloc),
        .resolve_valid  (sq_resolve_valid),
        .resolve_idx    (sq_resolve_idx),
        .resolve_addr   (sq_resolve_addr),
        .resolve_data   (sq_resolve_data),
        .resolve_size   (sq_resolve_size),
        .commit         (store_commit),
        .head           (sq_head),
        .tail           (sq_tail),
        .full           (sq_full),
        .head_resolved  (sq_head_resolved),
        .entry_resolved (sq_entry_resolved),
        .entry_addr     (sq_entry_addr),
        .entry_data     (sq_entry_data),
        .entry_size     (sq_entry_size),
        .commit_addr    (cache_write_addr),
        .commit_data    (cache_write_data),
        .commit_size    (cache_write_size)
    );

    load_dependence_check load_dependence_check_inst (
        .sq_head           (sq_head),
        .sq_entry_resolved (sq_entry_resolved),
        .sq_entry_addr     (sq_entry_addr),
        .sq_entry_data     (sq_entry_data),
        .sq_entry_size     (sq_entry_size),
        .lb_entry_resolved (lb_entry_resolved),
        .lb_entry_age      (lb_entry_age),
        .lb_entry_addr     (lb_entry_addr),
        .lb_entry_size     (lb_entry_size),
        .lb_entry_signed   (lb_entry_signed),
        .issue_ready       (issue_ready),
        .forward_ready     (forward_ready),
        .forward_data      (forward_data)
    );

    load_buffer load_buffer_inst (
        .clock          (clock),
        .rst            (rst),
        .flush          (flush),
        .alloc          (lb_alloc),
        .sq_tail        (sq_tail),
        .resolve_valid  (lb_resolve_valid),
        .resolve_idx    (lb_resolve_idx),
        .resolve_addr   (lb_resolve_addr),
        .resolve_size   (lb_resolve_size),
        .resolve_signed (lb_resolve_signed),
        .resolve_tag    (lb_resolve_tag),
        .issue_ready    (issue_ready),
        .forward_ready  (forward_ready),
        .forward_data   (forward_data),
        .alloc_idx      (lb_alloc_idx),
        .full           (lb_full),
        .entry_resolved (lb_entry_resolved),
        .entry_age      (lb_entry_age),
        .entry_addr     (lb_entry_addr),
        .entry_size     (lb_entry_size),
        .entry_signed   (lb_entry_signed),
        .read_valid     (cache_read_valid),
        .read_addr      (cache_read_addr),
        .read_size      (cache_read_size),
        .read_signed    (cache_read_signed),
        .read_tag       (cache_read_tag),
        .fwd_valid      (fwd_valid),
        .fwd_data       (fwd_data),
        .fwd_tag        (fwd_tag)
    );

endmodule

// ==== logic/load_buffer.sv ====
`timescale 1ns/1ps

module load_buffer
    import lsq_cfg_pkg::*, mem_access_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                flush,

    input  logic                alloc,
    input  sq_idx_t             sq_tail,
    input  logic                resolve_valid,
    input  lb_idx_t             resolve_idx,
    input  word_t               resolve_addr,
    input  mem_size_e           resolve_size,
    input  logic                resolve_signed,
    input  tag_t                resolve_tag,

    input  logic [LB_DEPTH-1:0] issue_ready,
    input  logic [LB_DEPTH-1:0] forward_ready,
    input  word_t               forward_data [LB_DEPTH],

    output lb_idx_t             alloc_idx,
    output logic                full,
    output logic [LB_DEPTH-1:0] entry_resolved,
    output sq_idx_t             entry_age [LB_DEPTH],
    output word_t               entry_addr [LB_DEPTH],
    output mem_size_e           entry_size [LB_DEPTH],
    output logic [LB_DEPTH-1:0] entry_signed,

    output logic                read_valid,
    output word_t               read_addr,
    output mem_size_e           read_size,
    output logic                read_signed,
    output tag_t                read_tag,

    output logic                fwd_valid,
    output word_t               fwd_data,
    output tag_t                fwd_tag
);

    logic [LB_DEPTH-1:0] busy;
    tag_t                entry_tag [LB_DEPTH];
    lb_idx_t             issue_idx;
    lb_idx_t             fwd_idx;
    logic                resolve_write;

    assign full          = &busy;
    assign resolve_write = resolve_valid && busy[resolve_idx] && !entry_resolved[resolve_idx];

    ////////////////////////////////////////
    // Lowest-index pickers
    ////////////////////////////////////////

    always_comb begin
        alloc_idx = '0;
        issue_idx = '0;
        fwd_idx   = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (!busy[j])         alloc_idx = lb_idx_t'(j);
            if (issue_ready[j])   issue_idx = lb_idx_t'(j);
            if (forward_ready[j]) fwd_idx   = lb_idx_t'(j);
        end
    end

    assign read_valid  = |issue_ready;
    assign read_addr   = entry_addr[issue_idx];
    assign read_size   = entry_size[issue_idx];
    assign read_signed = entry_signed[issue_idx];
    assign read_tag    = entry_tag[issue_idx];

    assign fwd_valid = |forward_ready;
    assign fwd_data  = forward_data[fwd_idx];
    assign fwd_tag   = entry_tag[fwd_idx];

    ////////////////////////////////////////
    // Entry state
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            busy           <= '0;
            entry_resolved <= '0;
        end else begin
            if (alloc) begin
                busy[alloc_idx]           <= 1'b1;
                entry_resolved[alloc_idx] <= 1'b0;
            end
            if (resolve_write) begin
                entry_resolved[resolve_idx] <= 1'b1;
            end
            // Issue and forward each free one entry
            if (read_valid) begin
                busy[issue_idx]           <= 1'b0;
                entry_resolved[issue_idx] <= 1'b0;
            end
            if (fwd_valid) begin
                busy[fwd_idx]           <= 1'b0;
                entry_resolved[fwd_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_age[alloc_idx] <= sq_tail;
        end
        if (resolve_write) begin
            entry_addr[resolve_idx]   <= resolve_addr;
            entry_size[resolve_idx]   <= resolve_size;
            entry_signed[resolve_idx] <= resolve_signed;
            entry_tag[resolve_idx]    <= resolve_tag;
        end
    end

endmodule

// ==== logic/load_dependence_check.sv ====
`timescale 1ns/1ps

module load_dependence_check
    import lsq_cfg_pkg::*, mem_access_pkg::*;
(
    input  sq_idx_t             sq_head,
    input  logic [SQ_DEPTH-1:0] sq_entry_resolved,
    input  word_t               sq_entry_addr [SQ_DEPTH],
    input  word_t               sq_entry_data [SQ_DEPTH],
    input  mem_size_e           sq_entry_size [SQ_DEPTH],

    input  logic [LB_DEPTH-1:0] lb_entry_resolved,
    input  sq_idx_t             lb_entry_age [LB_DEPTH],
    input  word_t               lb_entry_addr [LB_DEPTH],
    input  mem_size_e           lb_entry_size [LB_DEPTH],
    input  logic [LB_DEPTH-1:0] lb_entry_signed,

    output logic [LB_DEPTH-1:0] issue_ready,
    output logic [LB_DEPTH-1:0] forward_ready,
    output word_t               forward_data [LB_DEPTH]
);

    logic [LB_DEPTH-1:0] blocked;
    logic [LB_DEPTH-1:0] hit;
    logic [LB_DEPTH-1:0] covered;
    word_t               win_data [LB_DEPTH];
    logic [1:0]          win_offset [LB_DEPTH];

    ////////////////////////////////////////
    // Scan older stores, oldest first
    ////////////////////////////////////////

    always_comb begin
        sq_idx_t     older;
        sq_idx_t     sidx;
        logic [XLEN:0] s_lo;
        logic [XLEN:0] s_hi;
        logic [XLEN:0] l_lo;
        logic [XLEN:0] l_hi;

        for (int j = 0; j < LB_DEPTH; j++) begin
            blocked[j]    = 1'b0;
            hit[j]        = 1'b0;
            covered[j]    = 1'b0;
            win_data[j]   = '0;
            win_offset[j] = '0;
            // Stores from head up to the load's age are older
            older = lb_entry_age[j] - sq_head;
            l_lo  = {1'b0, lb_entry_addr[j]};
            l_hi  = l_lo + SIZE_BYTES[lb_entry_size[j]];
            for (int k = 0; k < SQ_DEPTH; k++) begin
                sidx = sq_head + sq_idx_t'(k);
                s_lo = {1'b0, sq_entry_addr[sidx]};
                s_hi = s_lo + SIZE_BYTES[sq_entry_size[sidx]];
                if (k < int'(older)) begin
                    if (!sq_entry_resolved[sidx]) begin
                        blocked[j] = 1'b1;
                    end else if ((s_lo < l_hi) && (l_lo < s_hi)) begin
                        // Later hits are younger and win
                        hit[j]        = 1'b1;
                        covered[j]    = (s_lo <= l_lo) && (s_hi >= l_hi);
                        win_data[j]   = sq_entry_data[sidx];
                        win_offset[j] = lb_entry_addr[j][1:0] - sq_entry_addr[sidx][1:0];
                    end
                end
            end
        end
    end

    // Partial overlap with the youngest hit waits like a blocker
    assign issue_ready   = lb_entry_resolved & ~blocked & ~hit;
    assign forward_ready = lb_entry_resolved & ~blocked & hit & covered;

    for (genvar j = 0; j < LB_DEPTH; j++) begin : g_align
        forward_align forward_align_inst (
            .store_data  (win_data[j]),
            .byte_offset (win_offset[j]),
            .size        (lb_entry_size[j]),
            .is_signed   (lb_entry_signed[j]),
            .load_data   (forward_data[j])
        );
    end

endmodule

// ==== logic/forward_align.sv ====
`timescale 1ns/1ps

module forward_align
    import lsq_cfg_pkg::*, mem_access_pkg::*;
(
    input  word_t     store_data,
    input  logic [1:0] byte_offset,
    input  mem_size_e size,
    input  logic      is_signed,
    output word_t     load_data
);

    word_t shifted;

    // Bring the addressed byte down to lane 0
    assign shifted = store_data >> {byte_offset, 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                load_data = is_signed ? {{24{shifted[7]}}, shifted[7:0]}
                                      : {24'b0, shifted[7:0]};
            end
            SIZE_HALF: begin
                load_data = is_signed ? {{16{shifted[15]}}, shifted[15:0]}
                                      : {16'b0, shifted[15:0]};
            end
            default: begin
                load_data = store_data;
            end
        endcase
    end

endmodule

// ==== logic/store_queue.sv ====
`timescale 1ns/1ps

module store_queue
    import lsq_cfg_pkg::*, mem_access_pkg::*;
(
    input  logic                clock,
    input  logic                rst,
    input  logic                flush,

    input  logic                alloc,
    input  logic                resolve_valid,
    input  sq_idx_t             resolve_idx,
    input  word_t               resolve_addr,
    input  word_t               resolve_data,
    input  mem_size_e           resolve_size,
    input  logic                commit,

    output sq_idx_t             head,
    output sq_idx_t             tail,
    output logic                full,
    output logic                head_resolved,

    output logic [SQ_DEPTH-1:0] entry_resolved,
    output word_t               entry_addr [SQ_DEPTH],
    output word_t               entry_data [SQ_DEPTH],
    output mem_size_e           entry_size [SQ_DEPTH],

    output word_t               commit_addr,
    output word_t               commit_data,
    output mem_size_e           commit_size
);

    sq_cnt_t count;
    logic    resolve_write;

    // A second resolve of the same entry is dropped
    assign resolve_write = resolve_valid && !entry_resolved[resolve_idx];

    // Keep one slot open so tail never catches head
    assign full          = (count == sq_cnt_t'(SQ_DEPTH - 1));
    assign head_resolved = entry_resolved[head];

    assign commit_addr = entry_addr[head];
    assign commit_data = entry_data[head];
    assign commit_size = entry_size[head];

    ////////////////////////////////////////
    // Pointers and resolved bits
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst || flush) begin
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            entry_resolved <= '0;
        end else begin
            if (alloc) begin
                entry_resolved[tail] <= 1'b0;
                tail                 <= tail + sq_idx_t'(1);
            end
            if (resolve_write) begin
                entry_resolved[resolve_idx] <= 1'b1;
            end
            // Head retires into the cache
            if (commit) begin
                entry_resolved[head] <= 1'b0;
                head                 <= head + sq_idx_t'(1);
            end
            case ({alloc, commit})
                2'b10:   count <= count + sq_cnt_t'(1);
                2'b01:   count <= count - sq_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Store payload
    always_ff @(posedge clock) begin
        if (resolve_write) begin
            entry_addr[resolve_idx] <= resolve_addr;
            entry_data[resolve_idx] <= resolve_data;
            entry_size[resolve_idx] <= resolve_size;
        end
    end

endmodule

// ==== logic/mem_access_pkg.sv ====
package mem_access_pkg;

    ////////////////////////////////////////
    // Access sizes
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // Bytes touched per size, indexed by the encoding
    // Encoding 3 is unused and treated as a word
    localparam logic [3:0][2:0] SIZE_BYTES = {
        3'd4,
        3'd4,
        3'd2,
        3'd1
    };

endpackage

// ==== logic/lsq_cfg_pkg.sv ====
package lsq_cfg_pkg;

    ////////////////////////////////////////
    // Queue depths
    ////////////////////////////////////////

    localparam int SQ_DEPTH = 8;
    localparam int LB_DEPTH = 8;

    // Index widths, also the width of a load's age
    localparam int SQ_IDX_W = $clog2(SQ_DEPTH);
    localparam int LB_IDX_W = $clog2(LB_DEPTH);

    // Store count must reach SQ_DEPTH-1
    localparam int SQ_CNT_W = $clog2(SQ_DEPTH + 1);

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////

    localparam int XLEN  = 32;
    localparam int TAG_W = 6;

    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [LB_IDX_W-1:0] lb_idx_t;
    typedef logic [SQ_CNT_W-1:0] sq_cnt_t;
    typedef logic [XLEN-1:0]     word_t;
    typedef logic [TAG_W-1:0]    tag_t;

endpackage
